/* filelist.f */
source/sensor_pkg.sv
source/sensor_line_fifo.sv
source/sensor_start_delay.sv
source/sensor_fifo.sv
source/sensor_test_pattern.sv
source/sensor_ctrl_regs.sv
source/sensor_channel.sv
tests/sensor_channel_tb.sv

/* tests/sensor_channel_tb.sv */
module sensor_channel_tb;
    import sensor_pkg::*;

    typedef struct packed {
        logic       pattern;                            // 1 test pattern, 0 sensor
        logic       en;                                 // channel enable
        logic       clr;                                // clear frame count before the row
        logic [7:0] lines;
        logic [7:0] len;                                // pixels per line
        logic [4:0] delay;                              // value written, may exceed 8
    } row_t;

    localparam int NROWS = 9;

    logic      iclk = 1'b0;
    logic      irst;
    pixel_t    sens_pxd;
    logic      sens_vact;
    logic      sens_hact;
    logic      reg_we;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    reg_data_t reg_rdata;
    pixel_t    pxd_out;
    logic      data_valid;
    logic      sof;
    logic      eof;

    row_t   rows [NROWS];
    pixel_t exp_pix [$];                                // model pixels in order
    int     exp_len [$];                                // model line lengths
    pixel_t got_pix [$];
    int     got_len [$];                                // data_valid burst lengths
    int     run_len;
    int     sof_cnt;
    int     eof_cnt;
    logic   sof_late;                                   // sof after a pixel
    logic   dv_late;                                    // pixel after eof
    int     row_errs;
    int     total_errs = 0;
    int     fails = 0;
    int     exp_frames = 0;
    time    wd_limit = 0;

    sensor_channel sensor_channel_i (
        .iclk       (iclk),
        .irst       (irst),
        .sens_pxd   (sens_pxd),
        .sens_vact  (sens_vact),
        .sens_hact  (sens_hact),
        .reg_we     (reg_we),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .pxd_out    (pxd_out),
        .data_valid (data_valid),
        .sof        (sof),
        .eof        (eof)
    );

    always #10 iclk = ~iclk;                            // 20 unit period

    // output monitor, samples away from the rising edge
    always @(negedge iclk) begin
        if (!irst) begin
            if (data_valid) begin
                if (eof_cnt != 0) dv_late = 1'b1;
                got_pix.push_back(pxd_out);
                run_len++;
            end else if (run_len != 0) begin
                got_len.push_back(run_len);             // burst ended
                run_len = 0;
            end
            if (sof) begin
                sof_cnt++;
                if (got_pix.size() != 0) sof_late = 1'b1;
            end
            if (eof) eof_cnt++;
        end
    end

    initial begin
        wait (wd_limit != 0);
        #(wd_limit);
        $display("Watchdog expired after %0t, the run did not complete", wd_limit);
        $display("Some tests failed");
        $finish;
    end

    task automatic load_table();
        // pattern, en, clr, lines, len, delay
        rows[0] = {1'b0, 1'b1, 1'b0, 8'd3, 8'd10, 5'd0};
        rows[1] = {1'b0, 1'b1, 1'b0, 8'd4, 8'd24, 5'd4};
        rows[2] = {1'b0, 1'b1, 1'b0, 8'd2, 8'd40, 5'd8};
        rows[3] = {1'b0, 1'b0, 1'b0, 8'd2, 8'd16, 5'd4};  // disabled frame
        rows[4] = {1'b1, 1'b1, 1'b0, 8'd3, 8'd20, 5'd0};
        rows[5] = {1'b1, 1'b1, 1'b1, 8'd3, 8'd20, 5'd4};
        rows[6] = {1'b1, 1'b1, 1'b0, 8'd3, 8'd20, 5'd12}; // clamps to 8
        rows[7] = {1'b1, 1'b1, 1'b0, 8'd5, 8'd33, 5'd2};
        rows[8] = {1'b0, 1'b1, 1'b0, 8'd3, 8'd1, 5'd8};   // single pixel lines
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("Error: time %0t signal %s got %0h expected %0h", $time, name, got, exp);
            row_errs++;
        end
    endtask

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        reg_addr  = a;
        reg_wdata = d;
        reg_we    = 1'b1;
        @(negedge iclk);
        reg_we    = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t a, output reg_data_t d);
        reg_addr = a;
        @(negedge iclk);
        d = reg_rdata;                                  // combinational read, settled
    endtask

    task automatic clear_monitor();
        got_pix.delete();
        got_len.delete();
        exp_pix.delete();
        exp_len.delete();
        run_len  = 0;
        sof_cnt  = 0;
        eof_cnt  = 0;
        sof_late = 1'b0;
        dv_late  = 1'b0;
    endtask

    task automatic drive_frame(input int lines, input int len, input logic en);
        pixel_t px;
        int     gap;
        sens_vact = 1'b1;
        repeat (3 + $urandom % 4) @(negedge iclk);     // lead-in before first line
        for (int l = 0; l < lines; l++) begin
            sens_hact = 1'b1;
            for (int p = 0; p < len; p++) begin
                px       = pixel_t'($urandom);
                sens_pxd = px;
                if (en) exp_pix.push_back(px);
                @(negedge iclk);
            end
            sens_hact = 1'b0;
            if (en) exp_len.push_back(len);
            gap = 10 + $urandom % 8;                    // random gap beyond the longest release
            repeat (gap) @(negedge iclk);
        end
        sens_vact = 1'b0;
        repeat (4) @(negedge iclk);
    endtask

    // ramp rule line*16 + pixel modulo 4096
    task automatic build_ramp(input int lines, input int len);
        for (int l = 0; l < lines; l++) begin
            for (int p = 0; p < len; p++) exp_pix.push_back(pixel_t'((l * 16 + p) % 4096));
            exp_len.push_back(len);
        end
    endtask

    task automatic compare_output(input logic en);
        int n;
        check_value("sof count", sof_cnt, en ? 1 : 0);
        check_value("eof count", eof_cnt, en ? 1 : 0);
        assert (!sof_late) else begin
            $display("sof arrived after the first pixel of the frame at %0t", $time);
            row_errs++;
        end
        assert (!dv_late) else begin
            $display("data_valid was seen after eof at %0t", $time);
            row_errs++;
        end
        check_value("line count", got_len.size(), exp_len.size());
        n = (got_len.size() < exp_len.size()) ? got_len.size() : exp_len.size();
        for (int k = 0; k < n; k++) check_value("line length", got_len[k], exp_len[k]);
        check_value("pixel count", got_pix.size(), exp_pix.size());
        n = (got_pix.size() < exp_pix.size()) ? got_pix.size() : exp_pix.size();
        for (int k = 0; k < n; k++) check_value("pxd_out", got_pix[k], exp_pix[k]);
    endtask

    task automatic report_test(input string name);
        $display("Test %s %s (%0d errors)", name, (row_errs == 0) ? "ok" : "FAILED", row_errs);
        total_errs += row_errs;
        if (row_errs != 0) fails++;
    endtask

    task automatic run_row(input int i);
        row_t      r;
        reg_data_t rd;
        r        = rows[i];
        row_errs = 0;
        if (r.clr) begin
            write_reg(REG_FRAMES, 16'hffff);            // any write clears
            exp_frames = 0;
            read_reg(REG_FRAMES, rd);
            check_value("REG_FRAMES", rd, 0);
        end
        write_reg(REG_PATTERN, {r.lines, r.len});
        write_reg(REG_DELAY, 16'(r.delay));
        read_reg(REG_DELAY, rd);
        check_value("REG_DELAY", rd, (r.delay > 8) ? 8 : int'(r.delay));
        clear_monitor();
        if (r.pattern) begin
            if (r.en) build_ramp(r.lines, r.len);
            write_reg(REG_CTRL, {14'd0, 1'b1, r.en});
            if (r.en) wait (eof_cnt != 0);
            write_reg(REG_CTRL, 16'd0);                 // stop before the next frame
        end else begin
            write_reg(REG_CTRL, {15'd0, r.en});
            drive_frame(r.lines, r.len, r.en);
            if (r.en) wait (eof_cnt != 0);
        end
        repeat (30) @(negedge iclk);                    // drain, catch stray output
        compare_output(r.en);
        if (r.en) exp_frames++;
        read_reg(REG_FRAMES, rd);
        check_value("REG_FRAMES", rd, exp_frames);
        report_test($sformatf("%0d %s lines %0d len %0d delay %0d en %0d", i,
                              r.pattern ? "pattern" : "sensor", r.lines, r.len, r.delay, r.en));
    endtask

    initial begin
        reg_data_t rd;
        time       limit;
        void'($urandom(61));
        irst      = 1'b1;
        sens_pxd  = '0;
        sens_vact = 1'b0;
        sens_hact = 1'b0;
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        clear_monitor();
        load_table();
        limit = 0;
        for (int i = 0; i < NROWS; i++) begin
            limit += (int'(rows[i].lines) * (int'(rows[i].len) + 40) + 200) * 20;
        end
        wd_limit = limit;                               // arms the watchdog
        repeat (4) @(negedge iclk);
        irst = 1'b0;

        row_errs = 0;
        check_value("data_valid", data_valid, 0);
        check_value("sof", sof, 0);
        check_value("eof", eof, 0);
        check_value("pxd_out", pxd_out, 0);
        for (int a = 0; a < 4; a++) begin
            read_reg(reg_addr_t'(a), rd);
            check_value("reg_rdata", rd, 0);
        end
        report_test("reset values");

        for (int i = 0; i < NROWS; i++) run_row(i);

        $display("Totals %0d tests, %0d failed, %0d failed checks", NROWS + 1, fails, total_errs);
        if (fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* source/sensor_channel.sv */
module sensor_channel #(
    parameter int FIFO_ADDR_BITS = 4
) (
    input  logic                  iclk,
    input  logic                  irst,
    input  sensor_pkg::pixel_t    sens_pxd,
    input  logic                  sens_vact,
    input  logic                  sens_hact,
    input  logic                  reg_we,
    input  sensor_pkg::reg_addr_t reg_addr,
    input  sensor_pkg::reg_data_t reg_wdata,
    output sensor_pkg::reg_data_t reg_rdata,
    output sensor_pkg::pixel_t    pxd_out,
    output logic                  data_valid,
    output logic                  sof,
    output logic                  eof
);
    import sensor_pkg::*;

    logic       enable;
    logic       pattern_sel;
    dly_t       rel_delay;
    logic [7:0] pat_len;
    logic [7:0] pat_lines;
    pixel_t     src_pxd;                                // sensor or pattern
    logic       src_vact;
    logic       src_hact;

    sensor_ctrl_regs sensor_ctrl_regs_i (
        .iclk        (iclk),
        .irst        (irst),
        .reg_we      (reg_we),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .sof         (sof),                             // output sof counted as frames
        .enable      (enable),
        .pattern_sel (pattern_sel),
        .rel_delay   (rel_delay),
        .pat_len     (pat_len),
        .pat_lines   (pat_lines)
    );

    sensor_test_pattern sensor_test_pattern_i (
        .iclk        (iclk),
        .irst        (irst),
        .enable      (enable),
        .pattern_sel (pattern_sel),
        .pat_len     (pat_len),
        .pat_lines   (pat_lines),
        .sens_pxd    (sens_pxd),
        .sens_vact   (sens_vact),
        .sens_hact   (sens_hact),
        .src_pxd     (src_pxd),
        .src_vact    (src_vact),
        .src_hact    (src_hact)
    );

    sensor_fifo #(
        .FIFO_ADDR_BITS (FIFO_ADDR_BITS)
    ) sensor_fifo_i (
        .iclk       (iclk),
        .irst       (irst),
        .pxd_in     (src_pxd),
        .vact       (src_vact),
        .hact       (src_hact),
        .rel_delay  (rel_delay),
        .pxd_out    (pxd_out),
        .data_valid (data_valid),
        .sof        (sof),
        .eof        (eof)
    );

endmodule

/* source/sensor_ctrl_regs.sv */
module sensor_ctrl_regs (
    input  logic                  iclk,
    input  logic                  irst,
    input  logic                  reg_we,
    input  sensor_pkg::reg_addr_t reg_addr,
    input  sensor_pkg::reg_data_t reg_wdata,
    output sensor_pkg::reg_data_t reg_rdata,
    input  logic                  sof,
    output logic                  enable,
    output logic                  pattern_sel,
    output sensor_pkg::dly_t      rel_delay,
    output logic [7:0]            pat_len,
    output logic [7:0]            pat_lines
);
    import sensor_pkg::*;

    localparam reg_data_t MAX_DELAY = 16'd8;            // keeps the fifo from overflowing

    reg_data_t frames;                                  // sof count
    logic      clr_frames;

    assign clr_frames = reg_we && (reg_addr == REG_FRAMES);

    always_ff @(posedge iclk) begin
        if (irst) begin
            enable      <= 1'b0;
            pattern_sel <= 1'b0;
            rel_delay   <= '0;
            pat_len     <= '0;
            pat_lines   <= '0;
        end else if (reg_we) begin
            case (reg_addr)
                REG_CTRL: begin
                    enable      <= reg_wdata[0];
                    pattern_sel <= reg_wdata[1];
                end
                REG_DELAY: begin
                    if (reg_wdata > MAX_DELAY) begin
                        rel_delay <= dly_t'(MAX_DELAY); // clamp
                    end else begin
                        rel_delay <= reg_wdata[3:0];
                    end
                end
                REG_PATTERN: begin
                    pat_len   <= reg_wdata[7:0];
                    pat_lines <= reg_wdata[15:8];
                end
                default: ;                              // frames handled below
            endcase
        end
    end

    always_ff @(posedge iclk) begin
        if (irst) begin
            frames <= '0;
        end else if (clr_frames) begin
            frames <= '0;                               // clear wins over a coincident sof
        end else if (sof) begin
            frames <= frames + 16'd1;
        end
    end

    always_comb begin
        case (reg_addr)
            REG_CTRL:    reg_rdata = {14'd0, pattern_sel, enable};
            REG_DELAY:   reg_rdata = {12'd0, rel_delay};
            REG_FRAMES:  reg_rdata = frames;
            REG_PATTERN: reg_rdata = {pat_lines, pat_len};
            default:     reg_rdata = '0;
        endcase
    end

endmodule

/* source/sensor_test_pattern.sv */
module sensor_test_pattern (
    input  logic               iclk,
    input  logic               irst,
    input  logic               enable,
    input  logic               pattern_sel,
    input  logic [7:0]         pat_len,
    input  logic [7:0]         pat_lines,
    input  sensor_pkg::pixel_t sens_pxd,
    input  logic               sens_vact,
    input  logic               sens_hact,
    output sensor_pkg::pixel_t src_pxd,
    output logic               src_vact,
    output logic               src_hact
);
    import sensor_pkg::*;

    localparam logic [7:0] IDLE_LAST = 8'd19;           // 20 cycle frame gap
    localparam logic [7:0] VGAP_LAST = 8'd3;            // 4 cycles vact before and after
    localparam logic [7:0] HGAP_LAST = 8'd15;           // 16 cycle line gap

    pat_state_t state;
    logic [7:0] cnt;                                    // cycles in state, pixel index in a line
    logic [7:0] line_cnt;
    logic       run;
    pixel_t     pat_pxd;
    logic       pat_vact;
    logic       pat_hact;

    assign run = enable && pattern_sel;

    always_ff @(posedge iclk) begin
        if (irst) begin
            state    <= PAT_IDLE;
            cnt      <= '0;
            line_cnt <= '0;
        end else if (!run) begin
            state    <= PAT_IDLE;                       // restart from the frame gap
            cnt      <= '0;
            line_cnt <= '0;
        end else begin
            case (state)
                PAT_IDLE: begin
                    if (cnt == IDLE_LAST) begin
                        cnt      <= '0;
                        line_cnt <= '0;
                        state    <= PAT_VGAP;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                PAT_VGAP: begin
                    if (cnt == VGAP_LAST) begin
                        cnt   <= '0;
                        state <= (line_cnt == pat_lines) ? PAT_IDLE : PAT_LINE; // done or lead-in
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                PAT_LINE: begin
                    if (cnt == pat_len - 8'd1) begin    // length 0 runs 256
                        cnt   <= '0;
                        state <= PAT_HGAP;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                PAT_HGAP: begin
                    if (cnt == HGAP_LAST) begin
                        cnt      <= '0;
                        line_cnt <= line_cnt + 8'd1;
                        state    <= (line_cnt + 8'd1 == pat_lines) ? PAT_VGAP : PAT_LINE;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                default: state <= PAT_IDLE;
            endcase
        end
    end

    assign pat_vact = (state != PAT_IDLE);
    assign pat_hact = (state == PAT_LINE);
    assign pat_pxd  = {line_cnt, 4'b0000} + pixel_t'(cnt); // line*16 + pixel, wraps at 4096

    // source select, enable gates the frame
    assign src_pxd  = pattern_sel ? pat_pxd : sens_pxd;
    assign src_vact = enable && (pattern_sel ? pat_vact : sens_vact);
    assign src_hact = enable && (pattern_sel ? pat_hact : sens_hact);

endmodule

/* source/sensor_fifo.sv */
module sensor_fifo #(
    parameter int FIFO_ADDR_BITS = 4
) (
    input  logic               iclk,
    input  logic               irst,
    input  sensor_pkg::pixel_t pxd_in,
    input  logic               vact,
    input  logic               hact,
    input  sensor_pkg::dly_t   rel_delay,
    output sensor_pkg::pixel_t pxd_out,
    output logic               data_valid,
    output logic               sof,
    output logic               eof
);
    import sensor_pkg::*;

    // write side
    pixel_t     pxd_r;                                  // registered pixel
    logic       vact_r;
    logic       vact_d;                                 // for frame edges
    logic       hact_r;
    logic       hact_d;                                 // for trailing word
    logic       sof_in;
    logic       eof_in;
    logic       we;
    fifo_word_t wdata;

    // read side
    fifo_word_t head;
    pixel_t     head_pxd;
    logic       head_hact;
    logic       head_sof;
    logic       head_eof;
    logic       nempty;
    logic       re;
    logic       re_line;                                // pop inside a released line
    logic       re_free;                                // pop of a non-line word
    logic       go;
    logic       active;
    logic       line_hold;                              // line start parked at head
    logic       hold_d;
    logic       line_start;
    logic       line_go;                                // delayed line start
    pixel_t     pxd_q;
    logic       dv_q;
    logic       sof_q;
    logic       eof_q;

    always_ff @(posedge iclk) begin
        pxd_r <= pxd_in;                                // payload, no reset
    end

    always_ff @(posedge iclk) begin
        if (irst) begin
            vact_r <= 1'b0;
            vact_d <= 1'b0;
            hact_r <= 1'b0;
            hact_d <= 1'b0;
        end else begin
            vact_r <= vact;
            vact_d <= vact_r;
            hact_r <= hact;
            hact_d <= hact_r;
        end
    end

    assign sof_in = vact_r && !vact_d;                  // frame start edge
    assign eof_in = vact_d && !vact_r;                  // frame end edge
    assign we     = sof_in || eof_in || hact_r || hact_d; // extra word after hact falls
    assign wdata  = {eof_in, sof_in, hact_r, pxd_r};

    sensor_line_fifo #(
        .ADDR_BITS (FIFO_ADDR_BITS)
    ) sensor_line_fifo_i (
        .iclk   (iclk),
        .irst   (irst),
        .we     (we),
        .wdata  (wdata),
        .re     (re),
        .rdata  (head),
        .nempty (nempty)
    );

    assign {head_eof, head_sof, head_hact, head_pxd} = head;

    assign go         = active || line_go;
    assign re_line    = go && nempty;
    assign re_free    = !go && nempty && !head_hact;    // flags pass straight through
    assign re         = re_line || re_free;
    assign line_hold  = !go && nempty && head_hact;     // wait here for the release
    assign line_start = line_hold && !hold_d;           // one pulse per line

    sensor_start_delay sensor_start_delay_i (
        .iclk (iclk),
        .irst (irst),
        .din  (line_start),
        .dly  (rel_delay),
        .dout (line_go)
    );

    always_ff @(posedge iclk) begin
        if (irst) begin
            hold_d <= 1'b0;
            active <= 1'b0;
            dv_q   <= 1'b0;
            sof_q  <= 1'b0;
            eof_q  <= 1'b0;
            pxd_q  <= '0;
        end else begin
            hold_d <= line_hold;
            if (re_line && !head_hact) begin
                active <= 1'b0;                         // trailing word ends the line
            end else if (line_go) begin
                active <= 1'b1;
            end
            dv_q  <= re_line && head_hact;              // one per popped pixel
            sof_q <= re && head_sof;
            eof_q <= re && head_eof;
            if (re_line && head_hact) begin
                pxd_q <= head_pxd;
            end
        end
    end

    assign pxd_out    = pxd_q;
    assign data_valid = dv_q;
    assign sof        = sof_q;
    assign eof        = eof_q;

endmodule

/* source/sensor_start_delay.sv */
module sensor_start_delay (
    input  logic             iclk,
    input  logic             irst,
    input  logic             din,
    input  sensor_pkg::dly_t dly,
    output logic             dout
);

    logic [15:0] sr;                                    // one stage per cycle

    always_ff @(posedge iclk) begin
        if (irst) begin
            sr <= '0;
        end else begin
            sr <= {sr[14:0], din};                      // shift toward msb
        end
    end

    // dly 0 gives one cycle, dly 15 gives sixteen
    assign dout = sr[dly];

endmodule

/* source/sensor_line_fifo.sv */
module sensor_line_fifo #(
    parameter int ADDR_BITS = 4
) (
    input  logic                   iclk,
    input  logic                   irst,
    input  logic                   we,
    input  sensor_pkg::fifo_word_t wdata,
    input  logic                   re,
    output sensor_pkg::fifo_word_t rdata,
    output logic                   nempty
);
    import sensor_pkg::*;

    localparam int DEPTH = 1 << ADDR_BITS;

    fifo_word_t           mem [DEPTH];                  // line storage
    logic [ADDR_BITS-1:0] wptr;
    logic [ADDR_BITS-1:0] rptr;
    logic [ADDR_BITS:0]   count;                        // words held
    logic                 full;
    logic                 do_wr;
    logic                 do_rd;

    assign full   = (count == DEPTH[ADDR_BITS:0]);
    assign nempty = (count != '0);
    assign do_wr  = we && !full;                        // write into full fifo dropped
    assign do_rd  = re && nempty;
    assign rdata  = mem[rptr];                          // head word, no read latency

    always_ff @(posedge iclk) begin
        if (do_wr) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge iclk) begin
        if (irst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wptr <= wptr + 1'b1;                    // wraps at depth
            end
            if (do_rd) begin
                rptr <= rptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // both or neither
            endcase
        end
    end

endmodule

/* source/sensor_pkg.sv */
package sensor_pkg;

    localparam int PIXEL_WIDTH = 12;                    // sensor data width

    typedef logic [PIXEL_WIDTH-1:0] pixel_t;            // one pixel
    typedef logic [PIXEL_WIDTH+2:0] fifo_word_t;        // {eof, sof, hact, pixel}

    typedef logic [15:0] reg_data_t;                    // register word
    typedef logic [1:0]  reg_addr_t;                    // register address
    typedef logic [3:0]  dly_t;                         // line release delay

    // register map
    localparam reg_addr_t REG_CTRL    = 2'd0;           // bit0 enable, bit1 pattern_sel
    localparam reg_addr_t REG_DELAY   = 2'd1;           // release delay, max 8
    localparam reg_addr_t REG_FRAMES  = 2'd2;           // sof count, write clears
    localparam reg_addr_t REG_PATTERN = 2'd3;           // {lines, length}

    // pattern generator states
    typedef enum logic [1:0] {
        PAT_IDLE,                                       // frame gap, vact low
        PAT_LINE,                                       // hact high, ramp pixels
        PAT_HGAP,                                       // line gap
        PAT_VGAP                                        // vact high around the lines
    } pat_state_t;

endpackage
